// ==== common/udp_oe_pkg.sv ====
package udp_oe_pkg;

    localparam int NUM_CHAN = 2;
    localparam int CHAN_W   = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;

    // DFH word addresses
    localparam logic [9:0] DFH_HEADER_ADDR               = 10'h000;
    localparam logic [9:0] DFH_ID_LO_ADDR                = 10'h001;
    localparam logic [9:0] DFH_ID_HI_ADDR                = 10'h002;
    localparam logic [9:0] DFH_REG_ADDR_OFFSET_ADDR      = 10'h003;
    localparam logic [9:0] DFH_REGSZ_PARAMS_GR_INST_ADDR = 10'h004;

    // common registers, shared by all channels
    localparam logic [9:0] SCRATCHPAD_ADDR         = 10'h005;
    localparam logic [9:0] NUM_CHANNELS_ADDR       = 10'h006;
    localparam logic [9:0] FPGA_MAC_ADDR           = 10'h007;
    localparam logic [9:0] FPGA_IP_ADDR            = 10'h008;
    localparam logic [9:0] FPGA_UDP_PORT_ADDR      = 10'h009;
    localparam logic [9:0] FPGA_NETMASK_ADDR       = 10'h00a;
    localparam logic [9:0] HOST_MAC_ADDR           = 10'h00b;
    localparam logic [9:0] HOST_IP_ADDR            = 10'h00c;
    localparam logic [9:0] HOST_UDP_PORT_ADDR      = 10'h00d;
    localparam logic [9:0] PAYLOAD_PER_PACKET_ADDR = 10'h00e;
    localparam logic [9:0] CHECKSUM_IP_ADDR        = 10'h00f;

    // channel block at word 0x20, 0x10 words per channel
    localparam logic [4:0] CHAN_REGION        = 5'd1;
    localparam logic [3:0] CHAN_INFO_REG      = 4'd0;
    localparam logic [3:0] CHAN_RESET_REG     = 4'd1;
    localparam logic [3:0] CHAN_STATUS_REG    = 4'd2;
    localparam logic [3:0] CHAN_MISC_CTRL_REG = 4'd3;

    // DFHv1 header fields
    localparam logic [3:0]  DFH_HDR_FTYPE       = 4'h3;
    localparam logic [7:0]  DFH_HDR_VER         = 8'h01;
    localparam logic [10:0] DFH_HDR_RSVD0       = 11'h0;
    localparam logic        DFH_HDR_EOL         = 1'b1;
    localparam logic [23:0] DFH_HDR_NEXT_DFH    = 24'h0;
    localparam logic [3:0]  DFH_HDR_FEATURE_REV = 4'h1;
    localparam logic [11:0] DFH_HDR_FEATURE_ID  = 12'h0;
    localparam logic [62:0] DFH_REG_ADDR_OFFSET = 63'h28;
    localparam logic        DFH_REL             = 1'b0;
    localparam logic [31:0] DFH_REG_SZ          = 32'h0000_0200;
    localparam logic        DFH_PARAMS          = 1'b0;
    localparam logic [14:0] DFH_GROUP           = 15'h0;
    localparam logic [15:0] DFH_INSTANCE        = 16'h0;

    localparam logic [63:0] DFH_HEADER = {DFH_HDR_FTYPE, DFH_HDR_VER, DFH_HDR_RSVD0,
                                          DFH_HDR_EOL, DFH_HDR_NEXT_DFH,
                                          DFH_HDR_FEATURE_REV, DFH_HDR_FEATURE_ID};
    localparam logic [63:0] DFH_ID_LO    = 64'hb8a3_2f6e_0c1d_4e79;
    localparam logic [63:0] DFH_ID_HI    = 64'h5d21_9a07_c4f3_8e16;
    localparam logic [63:0] DFH_REG_0X18 = {DFH_REG_ADDR_OFFSET, DFH_REL};
    localparam logic [63:0] DFH_REG_0X20 = {DFH_REG_SZ, DFH_PARAMS, DFH_GROUP, DFH_INSTANCE};

    localparam logic [63:0] REG_RD_BADADDR_DATA = 64'hbadd_badd_badd_badd;

    // header stream
    localparam int          HDR_BEATS      = 6;
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_TTL         = 8'h40;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'h11;

    // word address, seen either as a flat index or as a channel register
    typedef union packed {
        logic [9:0] idx;
        struct packed {
            logic [4:0] region;
            logic       chan_id;
            logic [3:0] chan_reg;
        } chan;
    } csr_addr_u;

endpackage

// ==== hw/user_csr.sv ====
`timescale 1ns/10ps

module user_csr import udp_oe_pkg::*; (
    input  logic                      uoe_csr_avmm,
    input  logic                      rst_local,
    input  logic [12:0]               address,
    input  logic                      read,
    input  logic                      write,
    input  logic [63:0]               writedata,
    output logic [63:0]               readdata,
    output logic                      readdatavalid,
    output logic [NUM_CHAN-1:0]       chan_wr,
    output logic [3:0]                chan_reg,
    output logic [63:0]               chan_wdata,
    input  logic [NUM_CHAN-1:0][63:0] chan_rdata,
    output logic [47:0]               fpga_mac,
    output logic [31:0]               fpga_ip,
    output logic [15:0]               fpga_udp_port,
    output logic [47:0]               host_mac,
    output logic [31:0]               host_ip,
    output logic [15:0]               host_udp_port,
    output logic [15:0]               payload_per_packet,
    output logic [15:0]               checksum_ip
);

    csr_addr_u   waddr;
    logic        in_chan;
    logic        last_chan;
    logic [63:0] scratchpad;
    logic [31:0] fpga_netmask;

    // byte address to word address
    assign waddr.idx = address[12:3];
    assign in_chan   = (waddr.chan.region == CHAN_REGION);
    assign last_chan = (int'(waddr.chan.chan_id) == NUM_CHAN - 1);

    // channel writes go straight through, channel number decoded here only
    assign chan_reg   = waddr.chan.chan_reg;
    assign chan_wdata = writedata;
    always_comb begin
        for (int i = 0; i < NUM_CHAN; i++) begin
            chan_wr[i] = write && in_chan && (int'(waddr.chan.chan_id) == i);
        end
    end

    // common register writes, truncated to field width
    always_ff @(posedge uoe_csr_avmm) begin
        if (rst_local) begin
            scratchpad         <= '0;
            fpga_mac           <= '0;
            fpga_ip            <= '0;
            fpga_udp_port      <= '0;
            fpga_netmask       <= '0;
            host_mac           <= '0;
            host_ip            <= '0;
            host_udp_port      <= '0;
            payload_per_packet <= '0;
            checksum_ip        <= '0;
        end else if (write) begin
            case (waddr.idx)
                SCRATCHPAD_ADDR:         scratchpad         <= writedata;
                FPGA_MAC_ADDR:           fpga_mac           <= writedata[47:0];
                FPGA_IP_ADDR:            fpga_ip            <= writedata[31:0];
                FPGA_UDP_PORT_ADDR:      fpga_udp_port      <= writedata[15:0];
                FPGA_NETMASK_ADDR:       fpga_netmask       <= writedata[31:0];
                HOST_MAC_ADDR:           host_mac           <= writedata[47:0];
                HOST_IP_ADDR:            host_ip            <= writedata[31:0];
                HOST_UDP_PORT_ADDR:      host_udp_port      <= writedata[15:0];
                PAYLOAD_PER_PACKET_ADDR: payload_per_packet <= writedata[15:0];
                CHECKSUM_IP_ADDR:        checksum_ip        <= writedata[15:0];
                default: ;
            endcase
        end
    end

    // one read in flight at most, data always one cycle later
    always_ff @(posedge uoe_csr_avmm) begin
        if (rst_local) begin
            readdatavalid <= 1'b0;
        end else begin
            readdatavalid <= read;
        end
    end

    always_ff @(posedge uoe_csr_avmm) begin
        if (read) begin
            if (in_chan) begin
                // info word: end of list, channel id, stride to next channel
                if (waddr.chan.chan_reg == CHAN_INFO_REG) begin
                    readdata <= {47'b0, last_chan, 7'b0, waddr.chan.chan_id, 8'h10};
                end else if (waddr.chan.chan_reg <= CHAN_MISC_CTRL_REG) begin
                    readdata <= chan_rdata[waddr.chan.chan_id];
                end else begin
                    readdata <= REG_RD_BADADDR_DATA;
                end
            end else begin
                case (waddr.idx)
                    DFH_HEADER_ADDR:               readdata <= DFH_HEADER;
                    DFH_ID_LO_ADDR:                readdata <= DFH_ID_LO;
                    DFH_ID_HI_ADDR:                readdata <= DFH_ID_HI;
                    DFH_REG_ADDR_OFFSET_ADDR:      readdata <= DFH_REG_0X18;
                    DFH_REGSZ_PARAMS_GR_INST_ADDR: readdata <= DFH_REG_0X20;
                    SCRATCHPAD_ADDR:               readdata <= scratchpad;
                    NUM_CHANNELS_ADDR:             readdata <= 64'(NUM_CHAN);
                    FPGA_MAC_ADDR:                 readdata <= {16'b0, fpga_mac};
                    FPGA_IP_ADDR:                  readdata <= {32'b0, fpga_ip};
                    FPGA_UDP_PORT_ADDR:            readdata <= {48'b0, fpga_udp_port};
                    FPGA_NETMASK_ADDR:             readdata <= {32'b0, fpga_netmask};
                    HOST_MAC_ADDR:                 readdata <= {16'b0, host_mac};
                    HOST_IP_ADDR:                  readdata <= {32'b0, host_ip};
                    HOST_UDP_PORT_ADDR:            readdata <= {48'b0, host_udp_port};
                    PAYLOAD_PER_PACKET_ADDR:       readdata <= {48'b0, payload_per_packet};
                    CHECKSUM_IP_ADDR:              readdata <= {48'b0, checksum_ip};
                    default:                       readdata <= REG_RD_BADADDR_DATA;
                endcase
            end
        end
    end

endmodule

// ==== hw/chan_ctrl.sv ====
`timescale 1ns/10ps

module chan_ctrl import udp_oe_pkg::*; (
    input  logic        uoe_csr_avmm,
    input  logic        rst_local,
    input  logic        chan_wr,
    input  logic [3:0]  chan_reg,
    input  logic [63:0] chan_wdata,
    output logic [63:0] chan_rdata,
    input  logic        tx_start,
    output logic        hdr_req,
    input  logic        hdr_ack,
    output logic        rx_rst,
    output logic [63:0] misc_ctrl
);

    logic        csr_rst;
    logic        tx_rst;
    logic        pending;
    logic        ack_q;
    logic [31:0] hdr_count;

    always_ff @(posedge uoe_csr_avmm) begin
        if (rst_local) begin
            {csr_rst, tx_rst, rx_rst} <= 3'b0;
            misc_ctrl                 <= '0;
        end else begin
            if (chan_wr && chan_reg == CHAN_RESET_REG) begin
                {csr_rst, tx_rst, rx_rst} <= chan_wdata[2:0];
            end
            // csr_rst wins over a misc_ctrl write
            if (csr_rst) begin
                misc_ctrl <= '0;
            end else if (chan_wr && chan_reg == CHAN_MISC_CTRL_REG) begin
                misc_ctrl <= chan_wdata;
            end
        end
    end

    // four-phase request, extra triggers while one is outstanding fold in
    always_ff @(posedge uoe_csr_avmm) begin
        if (rst_local) begin
            pending   <= 1'b0;
            hdr_req   <= 1'b0;
            ack_q     <= 1'b0;
            hdr_count <= '0;
        end else begin
            ack_q <= hdr_ack;
            if (tx_rst) begin
                pending <= 1'b0;
            end else if (pending && !hdr_req && !hdr_ack) begin
                hdr_req <= 1'b1;
                pending <= 1'b0;
            end else if (tx_start && !hdr_req) begin
                pending <= 1'b1;
            end
            if (hdr_req && hdr_ack) begin
                hdr_req <= 1'b0;
            end
            // count on the falling ack, one per completed header
            if (tx_rst) begin
                hdr_count <= '0;
            end else if (ack_q && !hdr_ack) begin
                hdr_count <= hdr_count + 32'd1;
            end
        end
    end

    always_comb begin
        case (chan_reg)
            CHAN_RESET_REG:     chan_rdata = {61'b0, csr_rst, tx_rst, rx_rst};
            CHAN_STATUS_REG:    chan_rdata = {hdr_count, 32'b0};
            CHAN_MISC_CTRL_REG: chan_rdata = misc_ctrl;
            default:            chan_rdata = '0;
        endcase
    end

endmodule

// ==== hdr_gen/hdr_arbiter.sv ====
`timescale 1ns/10ps

module hdr_arbiter import udp_oe_pkg::*; (
    input  logic                uoe_csr_avmm,
    input  logic                rst_local,
    input  logic [NUM_CHAN-1:0] hdr_req,
    output logic [NUM_CHAN-1:0] hdr_ack,
    output logic                start,
    output logic [CHAN_W-1:0]   start_chan,
    input  logic                done
);

    logic              busy;
    logic              acking;
    logic              found;
    logic [CHAN_W-1:0] last;
    logic [CHAN_W-1:0] pick;
    logic [CHAN_W-1:0] idx;

    // first raised request after the last served channel
    always_comb begin
        pick  = last;
        found = 1'b0;
        idx   = last;
        for (int k = 1; k <= NUM_CHAN; k++) begin
            idx = CHAN_W'((int'(last) + k) % NUM_CHAN);
            if (!found && hdr_req[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge uoe_csr_avmm) begin
        if (rst_local) begin
            busy       <= 1'b0;
            acking     <= 1'b0;
            start      <= 1'b0;
            start_chan <= '0;
            last       <= CHAN_W'(NUM_CHAN - 1);
            hdr_ack    <= '0;
        end else begin
            start <= 1'b0;
            if (!busy) begin
                if (found) begin
                    busy       <= 1'b1;
                    start      <= 1'b1;
                    start_chan <= pick;
                end
            end else if (!acking) begin
                if (done) begin
                    acking              <= 1'b1;
                    hdr_ack[start_chan] <= 1'b1;
                end
            end else if (!hdr_req[start_chan]) begin
                // request dropped, close the handshake
                hdr_ack[start_chan] <= 1'b0;
                acking              <= 1'b0;
                busy                <= 1'b0;
                last                <= start_chan;
            end
        end
    end

endmodule

// ==== hdr_gen/udp_hdr_builder.sv ====
`timescale 1ns/10ps

module udp_hdr_builder import udp_oe_pkg::*; (
    input  logic              uoe_csr_avmm,
    input  logic              rst_local,
    input  logic              start,
    input  logic [CHAN_W-1:0] start_chan,
    output logic              done,
    input  logic [47:0]       fpga_mac,
    input  logic [31:0]       fpga_ip,
    input  logic [15:0]       fpga_udp_port,
    input  logic [47:0]       host_mac,
    input  logic [31:0]       host_ip,
    input  logic [15:0]       host_udp_port,
    input  logic [15:0]       payload_per_packet,
    input  logic [15:0]       checksum_ip,
    output logic              hdr_valid,
    output logic [63:0]       hdr_data,
    output logic              hdr_last,
    input  logic              hdr_ready,
    output logic [CHAN_W-1:0] hdr_chan
);

    logic [2:0]              beat;
    logic [47:0]             s_fpga_mac;
    logic [31:0]             s_fpga_ip;
    logic [15:0]             s_fpga_port;
    logic [47:0]             s_host_mac;
    logic [31:0]             s_host_ip;
    logic [15:0]             s_host_port;
    logic [15:0]             s_payload;
    logic [15:0]             s_checksum;
    logic [15:0]             ip_len;
    logic [15:0]             udp_len;
    logic [HDR_BEATS*64-1:0] hdr_bits;

    // config held for the whole header so a CSR write cannot tear it
    always_ff @(posedge uoe_csr_avmm) begin
        if (start && !hdr_valid) begin
            s_fpga_mac  <= fpga_mac;
            s_fpga_ip   <= fpga_ip;
            s_fpga_port <= fpga_udp_port;
            s_host_mac  <= host_mac;
            s_host_ip   <= host_ip;
            s_host_port <= host_udp_port;
            s_payload   <= payload_per_packet;
            s_checksum  <= checksum_ip;
        end
    end

    always_ff @(posedge uoe_csr_avmm) begin
        if (rst_local) begin
            hdr_valid <= 1'b0;
            beat      <= '0;
            hdr_chan  <= '0;
        end else if (!hdr_valid) begin
            if (start) begin
                hdr_valid <= 1'b1;
                beat      <= '0;
                hdr_chan  <= start_chan;
            end
        end else if (hdr_ready) begin
            if (hdr_last) begin
                hdr_valid <= 1'b0;
            end else begin
                beat <= beat + 3'd1;
            end
        end
    end

    assign ip_len  = s_payload + 16'd28;
    assign udp_len = s_payload + 16'd8;

    // ethernet, ipv4, udp, then six pad bytes
    assign hdr_bits = {s_host_mac, s_fpga_mac, ETHERTYPE_IPV4,
                       8'h45, 8'h00, ip_len, 16'h0000, 16'h4000,
                       IP_TTL, IP_PROTO_UDP, s_checksum, s_fpga_ip, s_host_ip,
                       s_fpga_port, s_host_port, udp_len, 16'h0000,
                       48'h0};

    // byte 0 leaves first in the top bits
    assign hdr_data = hdr_bits[(HDR_BEATS - 1 - int'(beat))*64 +: 64];
    assign hdr_last = hdr_valid && (int'(beat) == HDR_BEATS - 1);
    assign done     = hdr_valid && hdr_ready && hdr_last;

endmodule

// ==== hw/udp_oe_ctrl_top.sv ====
`timescale 1ns/10ps

module udp_oe_ctrl_top import udp_oe_pkg::*; (
    input  logic                      uoe_csr_avmm,
    input  logic                      rst_local,
    input  logic [12:0]               address,
    input  logic                      read,
    input  logic                      write,
    input  logic [63:0]               writedata,
    output logic [63:0]               readdata,
    output logic                      readdatavalid,
    input  logic [NUM_CHAN-1:0]       tx_start,
    output logic [NUM_CHAN-1:0]       rx_rst,
    output logic [NUM_CHAN-1:0][63:0] misc_ctrl,
    output logic                      hdr_valid,
    output logic [63:0]               hdr_data,
    output logic                      hdr_last,
    input  logic                      hdr_ready,
    output logic [CHAN_W-1:0]         hdr_chan
);

    logic [NUM_CHAN-1:0]       chan_wr;
    logic [3:0]                chan_reg;
    logic [63:0]               chan_wdata;
    logic [NUM_CHAN-1:0][63:0] chan_rdata;
    logic [NUM_CHAN-1:0]       hdr_req;
    logic [NUM_CHAN-1:0]       hdr_ack;
    logic                      start;
    logic [CHAN_W-1:0]         start_chan;
    logic                      done;
    logic [47:0]               fpga_mac;
    logic [31:0]               fpga_ip;
    logic [15:0]               fpga_udp_port;
    logic [47:0]               host_mac;
    logic [31:0]               host_ip;
    logic [15:0]               host_udp_port;
    logic [15:0]               payload_per_packet;
    logic [15:0]               checksum_ip;

    user_csr u_csr (.*);

    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        chan_ctrl u_chan (
            .uoe_csr_avmm (uoe_csr_avmm),
            .rst_local    (rst_local),
            .chan_wr      (chan_wr[i]),
            .chan_reg     (chan_reg),
            .chan_wdata   (chan_wdata),
            .chan_rdata   (chan_rdata[i]),
            .tx_start     (tx_start[i]),
            .hdr_req      (hdr_req[i]),
            .hdr_ack      (hdr_ack[i]),
            .rx_rst       (rx_rst[i]),
            .misc_ctrl    (misc_ctrl[i])
        );
    end

    hdr_arbiter u_arb (.*);

    udp_hdr_builder u_bld (.*);

endmodule

// ==== verif/udp_oe_ctrl_assert.sv ====
`timescale 1ns/10ps

module udp_oe_ctrl_assert import udp_oe_pkg::*; (
    input logic                uoe_csr_avmm,
    input logic                rst_local,
    input logic                read,
    input logic                readdatavalid,
    input logic                hdr_valid,
    input logic                hdr_ready,
    input logic [63:0]         hdr_data,
    input logic [NUM_CHAN-1:0] hdr_req,
    input logic [NUM_CHAN-1:0] hdr_ack
);

    // read data comes exactly one cycle after the read
    a_rdv_after_read: assert property (@(posedge uoe_csr_avmm) disable iff (rst_local)
        read |=> readdatavalid) else $error("readdatavalid missing after read");

    a_rdv_needs_read: assert property (@(posedge uoe_csr_avmm) disable iff (rst_local)
        readdatavalid |-> $past(read)) else $error("readdatavalid without a read");

    // a stalled beat holds
    a_hdr_hold: assert property (@(posedge uoe_csr_avmm) disable iff (rst_local)
        hdr_valid && !hdr_ready |=> hdr_valid && $stable(hdr_data))
        else $error("hdr_data changed under stall");

    a_one_ack: assert property (@(posedge uoe_csr_avmm) disable iff (rst_local)
        $onehot0(hdr_ack)) else $error("more than one hdr_ack high");

    // ack may outlive req by the one cycle of the four-phase return
    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_ack
        a_ack_req: assert property (@(posedge uoe_csr_avmm) disable iff (rst_local)
            hdr_ack[i] |-> hdr_req[i] || $past(hdr_req[i]))
            else $error("hdr_ack high without hdr_req");
    end

endmodule

// ==== verif/tb_udp_oe_ctrl.sv ====
`timescale 1ns/10ps

module tb_udp_oe_ctrl import udp_oe_pkg::*; ();

    logic                      uoe_csr_avmm = 1'b0;
    logic                      rst_local;
    logic [12:0]               address;
    logic                      read;
    logic                      write;
    logic [63:0]               writedata;
    logic [63:0]               readdata;
    logic                      readdatavalid;
    logic [NUM_CHAN-1:0]       tx_start;
    logic [NUM_CHAN-1:0]       rx_rst;
    logic [NUM_CHAN-1:0][63:0] misc_ctrl;
    logic                      hdr_valid;
    logic [63:0]               hdr_data;
    logic                      hdr_last;
    logic                      hdr_ready;
    logic [CHAN_W-1:0]         hdr_chan;

    logic [31:0] lfsr_state = 32'hd4ac_5a08;
    logic [63:0] sh [0:15];
    logic [63:0] rd;
    logic [63:0] misc_val [0:NUM_CHAN-1];
    logic        rand_ready;
    int          errors;
    int          checks;
    int          tests;
    int          failed_tests;
    int          test_err0;
    string       test_name;
    int          hdr_seen [$];
    int          seen_cnt [0:NUM_CHAN-1];
    int          beat_idx;
    int          cur_chan;
    int          last_served;
    int          exp_first;

    udp_oe_ctrl_top UUT (.*);

    bind udp_oe_ctrl_top udp_oe_ctrl_assert u_assert (
        .uoe_csr_avmm  (uoe_csr_avmm),
        .rst_local     (rst_local),
        .read          (read),
        .readdatavalid (readdatavalid),
        .hdr_valid     (hdr_valid),
        .hdr_ready     (hdr_ready),
        .hdr_data      (hdr_data),
        .hdr_req       (hdr_req),
        .hdr_ack       (hdr_ack)
    );

    always #10 uoe_csr_avmm = ~uoe_csr_avmm;

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_word();
        logic [63:0] w;
        w = '0;
        for (int i = 0; i < 64; i++) begin
            w = {w[62:0], lfsr_bit()};
        end
        return w;
    endfunction

    function automatic logic [63:0] field_mask(input logic [9:0] wa);
        case (wa)
            FPGA_MAC_ADDR, HOST_MAC_ADDR:                   return {16'h0, {48{1'b1}}};
            FPGA_IP_ADDR, FPGA_NETMASK_ADDR, HOST_IP_ADDR: return {32'h0, {32{1'b1}}};
            FPGA_UDP_PORT_ADDR, HOST_UDP_PORT_ADDR,
            PAYLOAD_PER_PACKET_ADDR, CHECKSUM_IP_ADDR:      return {48'h0, {16{1'b1}}};
            default:                                        return {64{1'b1}};
        endcase
    endfunction

    function automatic logic [9:0] chan_addr(input int c, input logic [3:0] r);
        csr_addr_u a;
        a.chan.region   = CHAN_REGION;
        a.chan.chan_id  = 1'(c);
        a.chan.chan_reg = r;
        return a.idx;
    endfunction

    // expected header beat from the shadow registers with byte 0 first
    function automatic logic [63:0] ref_hdr_beat(input int beat);
        logic [383:0] hdr;
        logic [15:0]  pay;
        logic [15:0]  ip_len;
        logic [15:0]  udp_len;
        pay     = sh[PAYLOAD_PER_PACKET_ADDR][15:0];
        ip_len  = pay + 16'd28;
        udp_len = pay + 16'd8;
        hdr = {sh[HOST_MAC_ADDR][47:0], sh[FPGA_MAC_ADDR][47:0], ETHERTYPE_IPV4,
               8'h45, 8'h00, ip_len, 16'h0000, 16'h4000, IP_TTL, IP_PROTO_UDP,
               sh[CHECKSUM_IP_ADDR][15:0], sh[FPGA_IP_ADDR][31:0], sh[HOST_IP_ADDR][31:0],
               sh[FPGA_UDP_PORT_ADDR][15:0], sh[HOST_UDP_PORT_ADDR][15:0], udp_len,
               16'h0000, 48'h0};
        return hdr[383 - beat*64 -: 64];
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge uoe_csr_avmm);
        #1;
    endtask

    task automatic csr_write(input logic [9:0] wa, input logic [63:0] data);
        next_cycle();
        address   = {wa, 3'b000};
        writedata = data;
        write     = 1'b1;
        next_cycle();
        write = 1'b0;
    endtask

    task automatic csr_read(input logic [9:0] wa, output logic [63:0] data);
        int n;
        n = 0;
        next_cycle();
        address = {wa, 3'b000};
        read    = 1'b1;
        next_cycle();
        read = 1'b0;
        while (!readdatavalid && n < 8) begin
            next_cycle();
            n++;
        end
        if (readdatavalid) begin
            data = readdata;
        end else begin
            $display("read of word 0x%03h got no readdatavalid", wa);
            errors++;
            data = 'x;
        end
    endtask

    task automatic read_expect(input logic [9:0] wa, input logic [63:0] exp);
        csr_read(wa, rd);
        check($sformatf("readdata@0x%03h", wa), rd, exp);
    endtask

    // status may lag the last beat by the ack return
    task automatic wait_count(input int c, input int exp);
        int n;
        n = 0;
        csr_read(chan_addr(c, CHAN_STATUS_REG), rd);
        while (rd !== {32'(exp), 32'h0} && n < 20) begin
            csr_read(chan_addr(c, CHAN_STATUS_REG), rd);
            n++;
        end
        check($sformatf("status[%0d]", c), rd, {32'(exp), 32'h0});
    endtask

    task automatic wait_headers(input int count);
        int n;
        n = 0;
        while (hdr_seen.size() < count && n < 400) begin
            next_cycle();
            n++;
        end
        if (hdr_seen.size() < count) begin
            $display("timed out waiting for %0d headers, saw %0d", count, hdr_seen.size());
            errors++;
        end
    endtask

    task automatic pulse_tx(input logic [NUM_CHAN-1:0] m);
        next_cycle();
        tx_start = m;
        next_cycle();
        tx_start = '0;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_err0) begin
            $display("test %0d %s: ok", tests, test_name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", tests, test_name, errors - test_err0);
        end
    endtask

    always @(posedge uoe_csr_avmm) begin
        #1;
        hdr_ready = rand_ready ? lfsr_bit() : 1'b1;
    end

    // beat monitor samples mid-cycle where the stream is settled
    always @(negedge uoe_csr_avmm) begin
        if (!rst_local && hdr_valid && hdr_ready) begin
            if (beat_idx == 0) begin
                cur_chan = int'(hdr_chan);
            end else begin
                check("hdr_chan", 64'(hdr_chan), 64'(cur_chan));
            end
            check("hdr_data", hdr_data, ref_hdr_beat(beat_idx));
            check("hdr_last", 64'(hdr_last), 64'(beat_idx == HDR_BEATS - 1));
            if (hdr_last || beat_idx == HDR_BEATS - 1) begin
                hdr_seen.push_back(cur_chan);
                seen_cnt[cur_chan]++;
                beat_idx = 0;
            end else begin
                beat_idx++;
            end
        end
    end

    initial begin
        rst_local  = 1'b1;
        address    = '0;
        read       = 1'b0;
        write      = 1'b0;
        writedata  = '0;
        tx_start   = '0;
        hdr_ready  = 1'b1;
        rand_ready = 1'b0;
        for (int a = 0; a < 16; a++) begin
            sh[a] = '0;
        end
        for (int c = 0; c < NUM_CHAN; c++) begin
            seen_cnt[c] = 0;
        end
        repeat (16) @(posedge uoe_csr_avmm);
        #1;
        rst_local = 1'b0;

        begin_test("reset values");
        check("rx_rst", 64'(rx_rst), 64'h0);
        check("hdr_valid", 64'(hdr_valid), 64'h0);
        read_expect(DFH_HEADER_ADDR, DFH_HEADER);
        read_expect(DFH_ID_LO_ADDR, DFH_ID_LO);
        read_expect(DFH_ID_HI_ADDR, DFH_ID_HI);
        read_expect(DFH_REG_ADDR_OFFSET_ADDR, DFH_REG_0X18);
        read_expect(DFH_REGSZ_PARAMS_GR_INST_ADDR, DFH_REG_0X20);
        read_expect(NUM_CHANNELS_ADDR, 64'(NUM_CHAN));
        for (int c = 0; c < NUM_CHAN; c++) begin
            read_expect(chan_addr(c, CHAN_INFO_REG),
                        (64'(c == NUM_CHAN - 1) << 16) | (64'(c) << 8) | 64'h10);
        end
        for (int a = 5; a <= 15; a++) begin
            if (a != NUM_CHANNELS_ADDR) begin
                read_expect(10'(a), 64'h0);
            end
        end
        read_expect(10'h010, REG_RD_BADADDR_DATA);
        read_expect(chan_addr(0, 4'd4), REG_RD_BADADDR_DATA);
        read_expect(10'h040, REG_RD_BADADDR_DATA);
        read_expect(10'h3ff, REG_RD_BADADDR_DATA);
        end_test();

        begin_test("config write and read back");
        for (int a = 5; a <= 15; a++) begin
            if (a != NUM_CHANNELS_ADDR) begin
                rd = rand_word();
                csr_write(10'(a), rd);
                sh[a] = rd & field_mask(10'(a));
                read_expect(10'(a), sh[a]);
            end
        end
        end_test();

        begin_test("channel reset and misc_ctrl");
        for (int c = 0; c < NUM_CHAN; c++) begin
            misc_val[c] = rand_word();
            csr_write(chan_addr(c, CHAN_MISC_CTRL_REG), misc_val[c]);
            csr_write(chan_addr(c, CHAN_RESET_REG), 64'h1);
            read_expect(chan_addr(c, CHAN_RESET_REG), 64'h1);
            read_expect(chan_addr(c, CHAN_MISC_CTRL_REG), misc_val[c]);
            check($sformatf("misc_ctrl[%0d]", c), misc_ctrl[c], misc_val[c]);
        end
        check("rx_rst", 64'(rx_rst), 64'h3);
        // csr_rst on channel 0 only
        csr_write(chan_addr(0, CHAN_RESET_REG), 64'h4);
        read_expect(chan_addr(0, CHAN_MISC_CTRL_REG), 64'h0);
        read_expect(chan_addr(1, CHAN_MISC_CTRL_REG), misc_val[1]);
        check("misc_ctrl[0]", misc_ctrl[0], 64'h0);
        check("misc_ctrl[1]", misc_ctrl[1], misc_val[1]);
        check("rx_rst", 64'(rx_rst), 64'h2);
        for (int c = 0; c < NUM_CHAN; c++) begin
            csr_write(chan_addr(c, CHAN_RESET_REG), 64'h0);
            read_expect(chan_addr(c, CHAN_RESET_REG), 64'h0);
        end
        check("rx_rst", 64'(rx_rst), 64'h0);
        end_test();

        begin_test("single header");
        rand_ready = 1'b1;
        hdr_seen.delete();
        pulse_tx(2'b01);
        wait_headers(1);
        check("hdr_chan", 64'(hdr_seen.size() > 0 ? hdr_seen[0] : -1), 64'h0);
        // channel 0 is now the last one served
        last_served = 0;
        wait_count(0, 1);
        wait_count(1, 0);
        end_test();

        begin_test("two channels round robin");
        for (int r = 0; r < 4; r++) begin
            hdr_seen.delete();
            exp_first = (last_served + 1) % NUM_CHAN;
            pulse_tx(2'b11);
            wait_headers(2);
            if (hdr_seen.size() >= 2) begin
                check("hdr_chan first", 64'(hdr_seen[0]), 64'(exp_first));
                check("hdr_chan second", 64'(hdr_seen[1]), 64'((exp_first + 1) % NUM_CHAN));
            end
            last_served = (exp_first + 1) % NUM_CHAN;
            for (int c = 0; c < NUM_CHAN; c++) begin
                wait_count(c, seen_cnt[c]);
            end
        end
        end_test();

        begin_test("tx_rst holds off headers");
        hdr_seen.delete();
        for (int c = 0; c < NUM_CHAN; c++) begin
            csr_write(chan_addr(c, CHAN_RESET_REG), 64'h2);
            seen_cnt[c] = 0;
        end
        pulse_tx(2'b11);
        for (int n = 0; n < 100 && hdr_seen.size() == 0 && !hdr_valid; n++) begin
            next_cycle();
        end
        if (hdr_seen.size() != 0 || hdr_valid) begin
            $display("header started while tx_rst was set");
            errors++;
        end
        for (int c = 0; c < NUM_CHAN; c++) begin
            read_expect(chan_addr(c, CHAN_STATUS_REG), 64'h0);
            csr_write(chan_addr(c, CHAN_RESET_REG), 64'h0);
        end
        pulse_tx(2'b11);
        wait_headers(2);
        for (int c = 0; c < NUM_CHAN; c++) begin
            wait_count(c, 1);
        end
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
common/udp_oe_pkg.sv
hw/user_csr.sv
hw/chan_ctrl.sv
hdr_gen/hdr_arbiter.sv
hdr_gen/udp_hdr_builder.sv
hw/udp_oe_ctrl_top.sv
verif/udp_oe_ctrl_assert.sv
verif/tb_udp_oe_ctrl.sv
